// ==== hw/dcache_pkg.sv ====
// fixed geometry of 2 ways, 16 sets and 4-word lines over 32-bit byte addresses
package dcache_pkg;

    //////////////////////////////////////////////////
    // geometry
    //////////////////////////////////////////////////
    localparam int way_num        = 2;
    localparam int index_width    = 4;
    localparam int offset_width   = 2;
    localparam int words_per_line = 1 << offset_width;
    localparam int set_num        = 1 << index_width;
    localparam int tag_width      = 32 - index_width - offset_width - 2;
    localparam int index_lsb      = offset_width + 2;  // above word and byte bits

    localparam logic [1:0] mem_size_word = 2'd2;  // 4-byte transfers to L2

    //////////////////////////////////////////////////
    // entry types
    //////////////////////////////////////////////////
    typedef struct packed {
        logic                 valid;
        logic [tag_width-1:0] tag;
    } tagv_t;

    typedef logic [words_per_line-1:0][31:0] line_t;

    // taken from opcode bits 4:3
    typedef enum logic [1:0] {
        op_init      = 2'd0,  // write an empty entry by index and way
        op_inv_index = 2'd1,
        op_inv_hit   = 2'd2
    } op_code_t;

    typedef enum logic [3:0] {
        st_idle,
        st_lookup,
        st_miss_r,
        st_miss_r_wait,
        st_miss_w,
        st_hit_w,
        st_op,
        st_flush
    } dcache_state_t;

endpackage

// ==== hw/dcache_req_buf.sv ====
// payload fields are valid only while their request is in flight and carry no reset
`timescale 1ns/10ps

module dcache_req_buf (
    input  logic        clk,
    input  logic        rstn,
    input  logic        we,
    input  logic        valid,
    input  logic        is_op,
    input  logic        wr,
    input  logic        suc,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic [4:0]  opcode,
    output logic        buf_is_op,
    output logic        buf_wr,
    output logic        buf_suc,
    output logic [31:0] buf_addr,
    output logic [31:0] buf_wdata,
    output logic [3:0]  buf_wstrb,
    output logic [4:0]  buf_opcode
);
    logic capture;

    assign capture = we && valid;  // handshake taken

    // request kind
    always_ff @(posedge clk) begin
        if (!rstn) begin
            buf_is_op <= 1'b0;
            buf_wr    <= 1'b0;
            buf_suc   <= 1'b0;
        end else if (capture) begin
            buf_is_op <= is_op;
            buf_wr    <= wr;
            buf_suc   <= suc;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            buf_addr   <= addr;
            buf_wdata  <= wdata;
            buf_wstrb  <= wstrb;
            buf_opcode <= opcode;
        end
    end

endmodule

// ==== hw/dcache_lru.sv ====
// two-way LRU only; one bit per set names the way to evict next
`timescale 1ns/10ps

module dcache_lru
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [index_width-1:0] index,
    input  logic                   use0,
    input  logic                   use1,
    output logic                   victim
);
    logic [set_num-1:0] lru_bit;  // 1 means way 1 goes next

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_bit <= '0;
        end else if (use0) begin
            lru_bit[index] <= 1'b1;  // point at the other way
        end else if (use1) begin
            lru_bit[index] <= 1'b0;
        end
    end

    assign victim = lru_bit[index];

endmodule

// ==== hw/dcache_way_ram.sv ====
// read follows index combinationally; writes land at the clock edge and are blocked in reset
`timescale 1ns/10ps

module dcache_way_ram
    import dcache_pkg::*;
#(
    parameter type entry_t = logic [31:0]
)
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   we,
    input  logic [index_width-1:0] index,
    input  entry_t                 wentry,
    output entry_t                 rentry
);
    entry_t mem [set_num];  // no reset on contents

    always_ff @(posedge clk) begin
        if (rstn && we) begin
            mem[index] <= wentry;
        end
    end

    assign rentry = mem[index];  // async read

endmodule

// ==== hw/dcache_datapath.sv ====
// tag valid bits are undefined until init ops have run on every set and way
`timescale 1ns/10ps

module dcache_datapath
    import dcache_pkg::*;
(
    input  logic               clk,
    input  logic               rstn,
    input  logic [31:0]        buf_addr,
    input  logic [31:0]        buf_wdata,
    input  logic [3:0]         buf_wstrb,
    input  logic [way_num-1:0] data_we,
    input  logic [way_num-1:0] tagv_we,
    input  logic [way_num-1:0] tagv_inv,
    input  logic               tagv_init,
    input  logic               refill,
    input  logic               choose_way,
    input  logic               choose_return,
    input  line_t              mem_rline,
    output logic [way_num-1:0] hit,
    output logic [31:0]        rdata
);
    logic [index_width-1:0]  index;
    logic [tag_width-1:0]    tag;
    logic [offset_width-1:0] word;
    logic [offset_width-1:0] ret_word;
    line_t                   rline [way_num];

    //////////////////////////////////////////////////
    // address fields
    //////////////////////////////////////////////////
    assign index = buf_addr[index_lsb +: index_width];
    assign tag   = buf_addr[31 -: tag_width];
    assign word  = buf_addr[2 +: offset_width];

    //////////////////////////////////////////////////
    // per way tag and data arrays
    //////////////////////////////////////////////////
    for (genvar w = 0; w < way_num; w++) begin : g_way
        tagv_t rtagv;
        tagv_t wtagv;
        line_t wline;

        // init and invalidate both leave an empty entry
        assign wtagv  = '{valid: !(tagv_init || tagv_inv[w]), tag: tag};
        assign hit[w] = rtagv.valid && (rtagv.tag == tag);

        // refill takes the L2 line, a write hit merges strobed bytes
        always_comb begin
            wline = rline[w];
            if (refill) begin
                wline = mem_rline;
            end else begin
                for (int b = 0; b < 4; b++) begin
                    if (buf_wstrb[b]) begin
                        wline[word][8*b +: 8] = buf_wdata[8*b +: 8];
                    end
                end
            end
        end

        dcache_way_ram #(
            .entry_t (tagv_t)
        ) tagv_ram_i (
            .clk    (clk),
            .rstn   (rstn),
            .we     (tagv_we[w]),
            .index  (index),
            .wentry (wtagv),
            .rentry (rtagv)
        );

        dcache_way_ram #(
            .entry_t (line_t)
        ) data_ram_i (
            .clk    (clk),
            .rstn   (rstn),
            .we     (data_we[w]),
            .index  (index),
            .wentry (wline),
            .rentry (rline[w])
        );
    end

    // a return without refill is an uncached read with its word in slot 0
    assign ret_word = refill ? word : '0;
    assign rdata    = choose_return ? mem_rline[ret_word] : rline[choose_way][word];

endmodule

// ==== hw/dcache_fsm.sv ====
// write-through without allocate; flush is ignored once an L2 wait has opened
`timescale 1ns/10ps

module dcache_fsm
    import dcache_pkg::*;
(
    input  logic               clk,
    input  logic               rstn,
    input  logic               valid,
    input  logic               flush,
    input  logic               buf_is_op,
    input  logic               buf_wr,
    input  logic               buf_suc,
    input  logic [4:0]         buf_opcode,
    input  logic [31:0]        buf_addr,
    input  logic [way_num-1:0] hit,
    input  logic               victim,
    input  logic               mem_addr_ok,
    input  logic               mem_data_ok,
    output logic               ready,
    output logic               buf_we,
    output logic               rdata_valid,
    output logic               mem_req,
    output logic               mem_wr,
    output logic [way_num-1:0] data_we,
    output logic [way_num-1:0] tagv_we,
    output logic [way_num-1:0] tagv_inv,
    output logic               tagv_init,
    output logic               refill,
    output logic               choose_way,
    output logic               choose_return,
    output logic               use0,
    output logic               use1
);
    dcache_state_t      state;
    dcache_state_t      next_state;
    dcache_state_t      cur;           // state with ops told apart
    dcache_state_t      accept_state;  // where a finished transaction goes
    op_code_t           op_code;
    logic               miss;
    logic [way_num-1:0] hit_way;       // one-hot first hit
    logic [way_num-1:0] op_way;
    logic [way_num-1:0] victim_way;
    logic [way_num-1:0] init_we;
    logic [way_num-1:0] use_way;

    assign miss         = ~|hit || buf_suc;
    assign hit_way      = hit[0] ? 2'b01 : {hit[1], 1'b0};
    assign op_way       = buf_addr[0] ? 2'b10 : 2'b01;  // way from address bit 0
    assign victim_way   = victim ? 2'b10 : 2'b01;
    assign op_code      = op_code_t'(buf_opcode[4:3]);
    assign accept_state = valid ? st_lookup : st_idle;

    // ops enter through lookup and the buffered flag picks them out
    assign cur = (state == st_lookup && buf_is_op) ? st_op : state;

    assign tagv_we = data_we | tagv_inv | init_we;
    assign buf_we  = ready;  // capture whenever a request can be taken
    assign use0    = use_way[0];
    assign use1    = use_way[1];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////////////////////////
    // next state and controls
    //////////////////////////////////////////////////
    always_comb begin
        next_state    = state;
        ready         = 1'b0;
        rdata_valid   = 1'b0;
        mem_req       = 1'b0;
        mem_wr        = 1'b0;
        data_we       = '0;
        tagv_inv      = '0;
        init_we       = '0;
        tagv_init     = 1'b0;
        refill        = 1'b0;
        choose_way    = hit_way[1];
        choose_return = 1'b0;
        use_way       = '0;
        case (cur)
            st_idle: begin
                ready      = 1'b1;
                next_state = accept_state;
            end
            st_lookup: begin
                if (flush) begin
                    ready      = 1'b1;  // access dropped
                    next_state = st_flush;
                end else begin
                    if (buf_suc) begin
                        tagv_inv = hit_way;  // uncached access drops its line
                    end
                    if (buf_wr) begin
                        mem_req = 1'b1;
                        mem_wr  = 1'b1;
                        if (!miss) begin
                            data_we = hit_way;  // merge into the hit line
                            use_way = hit_way;
                        end
                        if (mem_addr_ok) begin
                            ready      = 1'b1;
                            next_state = accept_state;
                        end else begin
                            next_state = miss ? st_miss_w : st_hit_w;
                        end
                    end else if (miss) begin
                        mem_req    = 1'b1;
                        next_state = mem_addr_ok ? st_miss_r_wait : st_miss_r;
                    end else begin
                        rdata_valid = 1'b1;  // read hit
                        use_way     = hit_way;
                        ready       = 1'b1;
                        next_state  = accept_state;
                    end
                end
            end
            st_op: begin
                ready = 1'b1;
                if (flush) begin
                    next_state = st_flush;
                end else begin
                    next_state = accept_state;
                    case (op_code)
                        op_init: begin
                            tagv_init = 1'b1;
                            init_we   = op_way;
                        end
                        op_inv_index: tagv_inv = op_way;
                        op_inv_hit:   tagv_inv = hit_way;
                        default: ;  // reserved code has no effect
                    endcase
                end
            end
            st_flush: begin
                ready      = 1'b1;
                next_state = flush ? st_flush : accept_state;
            end
            st_hit_w, st_miss_w: begin
                mem_req = 1'b1;
                mem_wr  = 1'b1;
                if (mem_addr_ok) begin
                    ready      = 1'b1;
                    next_state = accept_state;
                end
            end
            st_miss_r: begin
                mem_req = 1'b1;
                if (mem_addr_ok) begin
                    next_state = st_miss_r_wait;
                end
            end
            st_miss_r_wait: begin
                if (mem_data_ok) begin
                    rdata_valid   = 1'b1;
                    choose_return = 1'b1;
                    ready         = 1'b1;
                    next_state    = accept_state;
                    if (!buf_suc) begin
                        data_we = victim_way;  // fill the LRU way
                        refill  = 1'b1;
                        use_way = victim_way;
                    end
                end
            end
            default: next_state = st_idle;
        endcase
    end

endmodule

// ==== hw/dcache_top.sv ====
// init ops must cover all 32 set/way pairs before any cached access; L2 transfers are one word
`timescale 1ns/10ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    // pipeline side
    input  logic        valid,
    input  logic        is_op,
    input  logic        wr,
    input  logic        suc,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic [4:0]  opcode,
    input  logic        flush,
    output logic        ready,
    output logic        stall,
    output logic [31:0] rdata,
    output logic        rdata_valid,
    // L2 side
    output logic        mem_req,
    output logic        mem_wr,
    output logic [1:0]  mem_size,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    output logic [3:0]  mem_wstrb,
    input  logic        mem_addr_ok,
    input  logic        mem_data_ok,
    input  line_t       mem_rline
);
    logic               buf_we;
    logic               buf_is_op;
    logic               buf_wr;
    logic               buf_suc;
    logic [31:0]        buf_addr;
    logic [31:0]        buf_wdata;
    logic [3:0]         buf_wstrb;
    logic [4:0]         buf_opcode;
    logic [way_num-1:0] hit;
    logic [way_num-1:0] data_we;
    logic [way_num-1:0] tagv_we;
    logic [way_num-1:0] tagv_inv;
    logic               tagv_init;
    logic               refill;
    logic               choose_way;
    logic               choose_return;
    logic               victim;
    logic               use0;
    logic               use1;

    assign stall     = ~ready;
    assign mem_size  = mem_size_word;
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = buf_wstrb;

    // cached reads fetch whole lines
    assign mem_addr = (buf_suc || buf_wr) ? {buf_addr[31:2], 2'b00}
                                          : {buf_addr[31:index_lsb], {index_lsb{1'b0}}};

    dcache_fsm fsm_i (
        .clk(clk), .rstn(rstn), .valid(valid), .flush(flush),
        .buf_is_op(buf_is_op), .buf_wr(buf_wr), .buf_suc(buf_suc),
        .buf_opcode(buf_opcode), .buf_addr(buf_addr), .hit(hit), .victim(victim),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok),
        .ready(ready), .buf_we(buf_we), .rdata_valid(rdata_valid),
        .mem_req(mem_req), .mem_wr(mem_wr), .data_we(data_we), .tagv_we(tagv_we),
        .tagv_inv(tagv_inv), .tagv_init(tagv_init), .refill(refill),
        .choose_way(choose_way), .choose_return(choose_return),
        .use0(use0), .use1(use1)
    );

    dcache_req_buf req_buf_i (
        .clk(clk), .rstn(rstn), .we(buf_we), .valid(valid),
        .is_op(is_op), .wr(wr), .suc(suc), .addr(addr), .wdata(wdata),
        .wstrb(wstrb), .opcode(opcode),
        .buf_is_op(buf_is_op), .buf_wr(buf_wr), .buf_suc(buf_suc),
        .buf_addr(buf_addr), .buf_wdata(buf_wdata), .buf_wstrb(buf_wstrb),
        .buf_opcode(buf_opcode)
    );

    dcache_lru lru_i (
        .clk    (clk),
        .rstn   (rstn),
        .index  (buf_addr[index_lsb +: index_width]),
        .use0   (use0),
        .use1   (use1),
        .victim (victim)
    );

    dcache_datapath datapath_i (
        .clk(clk), .rstn(rstn), .buf_addr(buf_addr), .buf_wdata(buf_wdata),
        .buf_wstrb(buf_wstrb), .data_we(data_we), .tagv_we(tagv_we),
        .tagv_inv(tagv_inv), .tagv_init(tagv_init), .refill(refill),
        .choose_way(choose_way), .choose_return(choose_return),
        .mem_rline(mem_rline), .hit(hit), .rdata(rdata)
    );

endmodule

// ==== test/dcache_tb.sv ====
// tags start undefined, so every set and way gets an init op first; addresses stay below 1 KiB
`timescale 1ns/10ps

module dcache_tb
    import dcache_pkg::*;
();
    localparam int          timeout_cycles = 200;
    localparam logic [31:0] seed           = 32'h7b3c7541;

    logic        clk;
    logic        rstn;
    logic        valid, is_op, wr, suc, flush;
    logic [31:0] addr, wdata;
    logic [3:0]  wstrb;
    logic [4:0]  opcode;
    logic        ready, stall, rdata_valid;
    logic [31:0] rdata;
    logic        mem_req, mem_wr;
    logic [1:0]  mem_size;
    logic [31:0] mem_addr, mem_wdata;
    logic [3:0]  mem_wstrb;
    logic        mem_addr_ok, mem_data_ok;
    line_t       mem_rline;

    // L2 model
    logic [31:0] l2_mem [256];
    logic [31:0] l2_rng;
    logic [31:0] rd_addr;
    logic [31:0] last_waddr, last_wdata;
    logic [3:0]  last_wstrb;
    logic [1:0]  last_size;
    logic        give_addr, give_data;
    int          l2_reads, l2_writes;
    int          req_wait, data_wait;

    // reference cache model
    logic [31:0]          ref_mem [256];
    logic                 ref_valid [set_num][way_num];
    logic [tag_width-1:0] ref_tag [set_num][way_num];
    logic                 ref_lru [set_num];  // way to evict next

    logic [31:0] stim_rng;
    logic [31:0] rand_addr;
    int          errors;
    int          checks;

    dcache_top dcache_top_i (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] fill_word(input logic [7:0] w);
        return 32'hc0de0000 ^ ({24'h0, w} * 32'h9e3779b1);
    endfunction

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    function automatic int find_way(input logic [31:0] a);
        for (int w = 0; w < way_num; w++) begin
            if (ref_valid[a[7:4]][w] && ref_tag[a[7:4]][w] == a[31:8]) begin
                return w;
            end
        end
        return -1;
    endfunction

    // returns the expected L2 reads of one read and updates the model
    function automatic int predict_read(input logic [31:0] a, input logic is_suc);
        int   w;
        logic miss;
        w    = find_way(a);
        miss = (w < 0);
        if (is_suc) begin
            if (!miss) begin
                ref_valid[a[7:4]][w] = 1'b0;  // uncached access drops the line
            end
            return 1;
        end
        if (miss) begin
            w                    = int'(ref_lru[a[7:4]]);
            ref_valid[a[7:4]][w] = 1'b1;
            ref_tag[a[7:4]][w]   = a[31:8];
        end
        ref_lru[a[7:4]] = (w == 0);
        return int'(miss);
    endfunction

    function automatic void predict_write(input logic [31:0] a, input logic [31:0] d,
                                          input logic [3:0] st, input logic is_suc);
        int w;
        for (int b = 0; b < 4; b++) begin
            if (st[b]) begin
                ref_mem[a[9:2]][8*b +: 8] = d[8*b +: 8];
            end
        end
        w = find_way(a);
        if (w >= 0 && is_suc) begin
            ref_valid[a[7:4]][w] = 1'b0;
        end else if (w >= 0) begin
            ref_lru[a[7:4]] = (w == 0);
        end
    endfunction

    function automatic line_t expected_line(input logic [31:0] a);
        line_t l;
        for (int j = 0; j < words_per_line; j++) begin
            l[j] = ref_mem[{a[9:4], 2'(j)}];
        end
        return l;
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s never arrived", what);
        $display("%0d checks, %0d errors", checks, errors + 1);
        $display("Finished with errors");
        $finish;
    endtask

    //////////////////////////////////////////////////
    // L2 model
    //////////////////////////////////////////////////
    always begin
        @(negedge clk);  // decide mid-cycle and drive after the next rising edge
        give_addr = 1'b0;
        give_data = 1'b0;
        if (data_wait > 0) begin
            data_wait = data_wait - 1;
            give_data = (data_wait == 0);
        end
        if (mem_req && !mem_addr_ok) begin
            if (req_wait > 0) begin
                req_wait = req_wait - 1;
            end else begin
                give_addr = 1'b1;
                last_size = mem_size;
                l2_rng    = xorshift(l2_rng);
                req_wait  = int'(l2_rng[1:0]);  // stall of the next request
                if (mem_wr) begin
                    l2_writes++;
                    last_waddr = mem_addr;
                    last_wdata = mem_wdata;
                    last_wstrb = mem_wstrb;
                    for (int b = 0; b < 4; b++) begin
                        if (mem_wstrb[b]) begin
                            l2_mem[mem_addr[9:2]][8*b +: 8] = mem_wdata[8*b +: 8];
                        end
                    end
                end else begin
                    l2_reads++;
                    rd_addr   = mem_addr;
                    data_wait = int'(l2_rng[9:8]) + 1;
                end
            end
        end
        @(posedge clk);
        #1;
        mem_addr_ok = give_addr;
        mem_data_ok = give_data;
        if (give_data) begin
            for (int j = 0; j < words_per_line; j++) begin
                mem_rline[j] = l2_mem[rd_addr[9:2] + 8'(j)];  // suc reads use word 0
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    task automatic issue_request(input logic op, input logic w, input logic s,
                                 input logic [31:0] a, input logic [31:0] d,
                                 input logic [3:0] st, input logic [4:0] oc);
        int t;
        valid  = 1'b1;
        is_op  = op;
        wr     = w;
        suc    = s;
        addr   = a;
        wdata  = d;
        wstrb  = st;
        opcode = oc;
        t      = 0;
        @(negedge clk);
        while (!ready) begin
            t++;
            if (t > timeout_cycles) begin
                stop_on_timeout("ready for a new request");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        valid = 1'b0;
    endtask

    task automatic wait_ready(input string name);
        int t;
        t = 0;
        @(negedge clk);
        while (!ready) begin
            t++;
            if (t > timeout_cycles) begin
                stop_on_timeout({"ready at the end of ", name});
            end
            @(negedge clk);
        end
    endtask

    task automatic read_access(input string name, input logic [31:0] a, input logic s);
        int          t;
        int          reads0;
        int          exp_reads;
        logic [31:0] exp_word;
        reads0    = l2_reads;
        exp_reads = predict_read(a, s);
        exp_word  = ref_mem[a[9:2]];
        t         = 0;
        issue_request(1'b0, 1'b0, s, a, '0, 4'h0, 5'h0);
        @(negedge clk);
        while (!rdata_valid) begin
            check_flag({name, " stall while waiting"}, 1'b1, stall);  // L2 wait open
            t++;
            if (t > timeout_cycles) begin
                stop_on_timeout({"rdata_valid in ", name});
            end
            @(negedge clk);
        end
        check_word(name, exp_word, rdata);
        check_flag({name, " stall on return"}, 1'b0, stall);
        if (mem_data_ok && !s) begin
            check_line({name, " refill"}, expected_line(a), mem_rline);
        end
        @(posedge clk);
        #1;
        check_count({name, " L2 reads"}, exp_reads, l2_reads - reads0);
        if (exp_reads > 0) begin
            check_word({name, " size"}, 32'd2, {30'h0, last_size});
        end
    endtask

    task automatic write_access(input string name, input logic [31:0] a, input logic [31:0] d,
                                input logic [3:0] st, input logic s);
        int reads0;
        int writes0;
        reads0  = l2_reads;
        writes0 = l2_writes;
        predict_write(a, d, st, s);
        issue_request(1'b0, 1'b1, s, a, d, st, 5'h0);
        wait_ready(name);
        @(posedge clk);
        #1;
        check_count({name, " L2 writes"}, 1, l2_writes - writes0);
        check_count({name, " L2 reads"}, 0, l2_reads - reads0);
        check_word({name, " address"}, {a[31:2], 2'b00}, last_waddr);
        check_word({name, " data"}, d, last_wdata);
        check_word({name, " strobe"}, {28'h0, st}, {28'h0, last_wstrb});
        check_word({name, " size"}, 32'd2, {30'h0, last_size});
    endtask

    // bit 0 of the address names the way for index ops
    task automatic run_op(input string name, input op_code_t code, input logic [31:0] a);
        int w;
        w = (code == op_inv_hit) ? find_way(a) : int'(a[0]);
        if (w >= 0) begin
            ref_valid[a[7:4]][w] = 1'b0;
        end
        issue_request(1'b1, 1'b0, 1'b0, a, '0, 4'h0, {code, 3'b000});
        wait_ready(name);
        @(posedge clk);
        #1;
    endtask

    // four hits on one cached line with valid held high throughout
    task automatic read_burst(input string name, input logic [31:0] base);
        int hits;
        int reads0;
        int exp_reads;
        hits      = 0;
        reads0    = l2_reads;
        exp_reads = 0;
        valid     = 1'b1;
        is_op     = 1'b0;
        wr        = 1'b0;
        suc       = 1'b0;
        addr      = base;
        for (int i = 0; i < words_per_line; i++) begin
            @(posedge clk);
            #1;
            addr  = base + 32'(4 * (i + 1));
            valid = (i < words_per_line - 1);
            exp_reads += predict_read(base + 32'(4 * i), 1'b0);
            @(negedge clk);
            if (rdata_valid) begin
                hits++;
            end
            check_word(name, ref_mem[base[9:2] + 8'(i)], rdata);
        end
        @(posedge clk);
        #1;
        check_count({name, " rdata_valid cycles"}, words_per_line, hits);
        check_count({name, " L2 reads"}, exp_reads, l2_reads - reads0);
    endtask

    task automatic flush_read(input string name, input logic [31:0] a);
        int reads0;
        int seen_rv;
        int seen_req;
        int seen_busy;
        reads0    = l2_reads;
        seen_rv   = 0;
        seen_req  = 0;
        seen_busy = 0;
        flush     = 1'b1;
        issue_request(1'b0, 1'b0, 1'b0, a, '0, 4'h0, 5'h0);
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            seen_rv   += int'(rdata_valid);
            seen_req  += int'(mem_req);
            seen_busy += int'(!ready);
            @(posedge clk);
            #1;
            valid = (i == 2);  // a request taken during flush is dropped too
        end
        flush = 1'b0;
        wait_ready(name);
        @(posedge clk);
        #1;
        check_count({name, " rdata_valid"}, 0, seen_rv);
        check_count({name, " mem_req cycles"}, 0, seen_req);
        check_count({name, " cycles without ready"}, 0, seen_busy);
        check_count({name, " L2 reads"}, 0, l2_reads - reads0);
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial begin
        clk         = 1'b0;
        rstn        = 1'b0;
        valid       = 1'b0;
        is_op       = 1'b0;
        wr          = 1'b0;
        suc         = 1'b0;
        flush       = 1'b0;
        addr        = '0;
        wdata       = '0;
        wstrb       = '0;
        opcode      = '0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rline   = '0;
        l2_reads    = 0;
        l2_writes   = 0;
        l2_rng      = seed;
        stim_rng    = seed;
        errors      = 0;
        checks      = 0;
        for (int i = 0; i < 256; i++) begin
            l2_mem[i]  = fill_word(8'(i));
            ref_mem[i] = fill_word(8'(i));
        end
        for (int s = 0; s < set_num; s++) begin
            ref_lru[s] = 1'b0;
            for (int w = 0; w < way_num; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
            end
        end
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;

        for (int s = 0; s < set_num; s++) begin
            for (int w = 0; w < way_num; w++) begin
                run_op("init", op_init, 32'(s << index_lsb) | 32'(w));
            end
        end

        for (int i = 0; i < 8; i++) begin
            read_access("first read", 32'(i * 32'h84), 1'b0);
        end
        read_access("repeat read", 32'h84, 1'b0);
        read_burst("back-to-back hits", 32'h80);

        write_access("write hit", 32'h88, 32'h1234abcd, 4'b0110, 1'b0);
        read_access("read after write hit", 32'h88, 1'b0);
        write_access("write miss", 32'h3f4, 32'h0badf00d, 4'b1111, 1'b0);
        read_access("read after write miss", 32'h3f4, 1'b0);

        // three lines of set 5
        read_access("lru a", 32'h050, 1'b0);
        read_access("lru b", 32'h150, 1'b0);
        read_access("lru a again", 32'h054, 1'b0);
        read_access("lru c", 32'h250, 1'b0);
        read_access("lru b again", 32'h158, 1'b0);
        read_access("lru a last", 32'h05c, 1'b0);

        read_access("suc read", 32'h254, 1'b1);
        read_access("suc read cached line", 32'h05c, 1'b1);
        read_access("read after suc", 32'h05c, 1'b0);
        write_access("suc write", 32'h88, 32'h5555aaaa, 4'b1001, 1'b1);
        read_access("read after suc write", 32'h88, 1'b0);
        read_access("fill for index inv", 32'h1c0, 1'b0);
        run_op("inv index way 0", op_inv_index, 32'h1c0);
        run_op("inv index way 1", op_inv_index, 32'h1c1);
        read_access("read after index inv", 32'h1c0, 1'b0);
        read_access("fill for hit inv", 32'h2e0, 1'b0);
        run_op("inv hit", op_inv_hit, 32'h2e0);
        read_access("read after hit inv", 32'h2e4, 1'b0);

        for (int i = 0; i < 40; i++) begin
            stim_rng  = xorshift(stim_rng);
            rand_addr = stim_rng & 32'h3fc;
            if (stim_rng[31:29] == 3'd0) begin
                write_access("random write", rand_addr, xorshift(stim_rng),
                             stim_rng[23:20] | 4'b0001, 1'b0);
            end else begin
                read_access("random read", rand_addr, stim_rng[28:24] == 5'd0);
            end
        end

        flush_read("flush in lookup", 32'h3a0);
        read_access("read after flush", 32'h3a0, 1'b0);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hw/dcache_pkg.sv
hw/dcache_req_buf.sv
hw/dcache_lru.sv
hw/dcache_way_ram.sv
hw/dcache_datapath.sv
hw/dcache_fsm.sv
hw/dcache_top.sv
test/dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dcache testbench, then look for the fail message in the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sources.f --top-module dcache_tb \
    -Mdir obj_dir -o dcache_sim
./obj_dir/dcache_sim > sim.log
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
